/* src/lsu_op_pkg.sv */
package lsu_op_pkg;

    // access size, encoded as funct3[1:0]
    // 2'b11 is never produced by decode
    typedef enum logic [1:0] {
        width_byte = 2'b00,
        width_half = 2'b01,
        width_word = 2'b10
    } mem_width_t;

    // exception code carried down the pipe
    typedef logic [6:0] exp_code_t;

    localparam exp_code_t exp_none           = 7'd0;
    localparam exp_code_t exp_illegal        = 7'd2;
    localparam exp_code_t exp_load_misalign  = 7'd4;
    localparam exp_code_t exp_store_misalign = 7'd6;

    // destination register index
    typedef logic [4:0] reg_idx_t;

    // raw instruction word
    typedef logic [31:0] instr_t;

    // major opcodes of the two memory classes
    localparam logic [6:0] opc_load  = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;

endpackage

/* src/lsu_mem_pkg.sv */
package lsu_mem_pkg;

    // cpu side address and data
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // one enable per byte lane
    typedef logic [3:0] byte_en_t;

    // byte address space actually decoded
    localparam int addr_bits   = 8;
    localparam int offset_bits = 2;

    // backing store depth in words
    localparam int mem_words = 64;

    // direct-mapped geometry
    localparam int cache_lines = 8;
    localparam int idx_bits    = 3;
    localparam int tag_bits    = addr_bits - idx_bits - offset_bits;

    typedef logic [idx_bits-1:0]              line_idx_t;
    typedef logic [tag_bits-1:0]              tag_t;
    typedef logic [addr_bits-offset_bits-1:0] word_idx_t;

    // extra cycles spent on a read miss
    localparam int miss_penalty = 3;

endpackage

/* src/lsu_if.sv */
`timescale 1ns/1ps

// decoded memory op, decode to execute
interface lsu_dec_if;
    import lsu_op_pkg::*;
    import lsu_mem_pkg::*;

    logic       valid;
    logic       write;
    mem_width_t width;
    logic       sign_ext;
    reg_idx_t   rd;
    data_t      base;
    data_t      imm;
    data_t      st_data;
    exp_code_t  exp;

    modport producer (output valid, write, width, sign_ext, rd, base, imm, st_data, exp);
    modport consumer (input  valid, write, width, sign_ext, rd, base, imm, st_data, exp);
endinterface

// cache request plus the fields that ride along to result
interface lsu_req_if;
    import lsu_op_pkg::*;
    import lsu_mem_pkg::*;

    logic       valid;
    logic       op;
    addr_t      addr;
    byte_en_t   write_type;
    data_t      w_data;
    reg_idx_t   rd;
    mem_width_t width;
    logic       sign_ext;
    exp_code_t  exp;

    modport producer (output valid, op, addr, write_type, w_data, rd, width, sign_ext, exp);
    // access fields only
    modport cache    (input  valid, op, addr, write_type, w_data);
    // side fields, plus addr for the lane select
    modport result   (input  valid, op, addr, rd, width, sign_ext, exp);
endinterface

/* src/lsu_decode.sv */
`timescale 1ns/1ps

module lsu_decode (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  lsu_op_pkg::instr_t in_instr,
    input  lsu_mem_pkg::data_t in_rs1,
    input  lsu_mem_pkg::data_t in_rs2,
    input  logic               stall,
    lsu_dec_if.producer        dec
);
    import lsu_op_pkg::*;
    import lsu_mem_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_load;
    logic       is_store;
    logic       supported;
    mem_width_t width_n;
    data_t      imm_n;

    assign opcode   = in_instr[6:0];
    assign funct3   = in_instr[14:12];
    assign is_load  = (opcode == opc_load);
    assign is_store = (opcode == opc_store);

    // loads: lb lh lw lbu lhu, stores: sb sh sw
    assign supported = (funct3[1:0] != 2'b11) &&
                       ((is_load && !(funct3[2] && funct3[1])) || (is_store && !funct3[2]));

    // size straight from funct3[1:0]
    // ops outside the set park on word
    assign width_n = supported ? mem_width_t'(funct3[1:0]) : width_word;

    // s-type splits the immediate around rd
    assign imm_n = is_store ? {{20{in_instr[31]}}, in_instr[31:25], in_instr[11:7]}
                            : {{20{in_instr[31]}}, in_instr[31:20]};

    always_ff @(posedge clk) begin
        if (reset) begin
            dec.valid <= 1'b0;
        end else if (!stall) begin
            dec.valid <= in_valid;
        end
    end

    // payload only moves with a live instruction
    always_ff @(posedge clk) begin
        if (!stall && in_valid) begin
            dec.write    <= is_store && supported;
            dec.width    <= width_n;
            // funct3[2] marks the unsigned loads
            dec.sign_ext <= is_load && !funct3[2];
            dec.rd       <= is_store ? reg_idx_t'(0) : in_instr[11:7];
            dec.base     <= in_rs1;
            dec.imm      <= imm_n;
            dec.st_data  <= in_rs2;
            dec.exp      <= supported ? exp_none : exp_illegal;
        end
    end

    // execute builds its byte enables from width
    a_width_legal : assert property (@(posedge clk) disable iff (reset)
        dec.valid |-> (dec.width inside {width_byte, width_half, width_word}));

endmodule

/* src/lsu_execute.sv */
`timescale 1ns/1ps

module lsu_execute (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    lsu_dec_if.consumer dec,
    lsu_req_if.producer req
);
    import lsu_op_pkg::*;
    import lsu_mem_pkg::*;

    addr_t      addr_n;
    logic [1:0] off;
    byte_en_t   be_base;
    logic       misalign;
    exp_code_t  exp_n;
    logic       valid_q;
    exp_code_t  exp_q;

    // effective address
    assign addr_n = dec.base + dec.imm;
    assign off    = addr_n[1:0];

    // lane mask before the shift
    always_comb begin
        case (dec.width)
            width_byte: be_base = 4'b0001;
            width_half: be_base = 4'b0011;
            default:    be_base = 4'b1111;
        endcase
    end

    // half needs even, word needs a multiple of four
    assign misalign = ((dec.width == width_half) && off[0]) ||
                      ((dec.width == width_word) && (off != 2'b00));

    // an illegal op from decode wins over misalignment
    always_comb begin
        if (dec.exp != exp_none) begin
            exp_n = dec.exp;
        end else if (misalign) begin
            exp_n = dec.write ? exp_store_misalign : exp_load_misalign;
        end else begin
            exp_n = exp_none;
        end
    end

    // control state, exp kept clean when the stage is empty
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            exp_q   <= exp_none;
        end else if (!stall) begin
            valid_q <= dec.valid;
            exp_q   <= dec.valid ? exp_n : exp_none;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && dec.valid) begin
            req.op         <= dec.write;
            req.addr       <= addr_n;
            // no enables at all for a read
            req.write_type <= dec.write ? byte_en_t'(be_base << off) : byte_en_t'(0);
            // store data moved into its byte lane
            req.w_data     <= dec.st_data << {off, 3'b000};
            req.rd         <= dec.rd;
            req.width      <= dec.width;
            req.sign_ext   <= dec.sign_ext;
        end
    end

    // faulting ops never reach the cache
    // hidden while result waits so the cache sees each op once
    assign req.valid = valid_q && (exp_q == exp_none) && !stall;
    assign req.exp   = exp_q;

    a_read_no_be : assert property (@(posedge clk) disable iff (reset)
        (valid_q && !req.op) |-> (req.write_type == '0));

endmodule

/* src/lsu_dcache.sv */
`timescale 1ns/1ps

module lsu_dcache (
    input  logic               clk,
    input  logic               reset,
    lsu_req_if.cache           req,
    output logic               data_valid,
    output lsu_mem_pkg::data_t r_data
);
    import lsu_mem_pkg::*;

    typedef enum logic [1:0] {
        idle,
        miss_wait,
        respond
    } state_t;

    typedef logic [$clog2(miss_penalty)-1:0] cnt_t;

    state_t                 state;
    cnt_t                   miss_cnt;
    logic [cache_lines-1:0] line_vld;
    tag_t                   tag_arr   [cache_lines];
    data_t                  line_data [cache_lines];
    data_t                  store_mem [mem_words];
    word_idx_t              req_widx;
    line_idx_t              req_idx;
    tag_t                   req_tag;
    word_idx_t              fill_widx;
    line_idx_t              fill_idx;
    logic                   hit;
    logic                   accept;
    logic                   fill_done;

    // byte-enable merge, shared by line and store
    function automatic data_t merge_bytes(data_t old_word, data_t new_word, byte_en_t be);
        data_t merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

    // store starts out all zero
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            store_mem[i] = '0;
        end
    end

    // {tag, index} is the word index
    assign req_widx  = req.addr[addr_bits-1:offset_bits];
    assign req_idx   = req_widx[idx_bits-1:0];
    assign req_tag   = req_widx[addr_bits-offset_bits-1:idx_bits];
    assign fill_idx  = fill_widx[idx_bits-1:0];
    assign hit       = line_vld[req_idx] && (tag_arr[req_idx] == req_tag);
    // no new work while a fill is counting down
    assign accept    = req.valid && (state != miss_wait);
    assign fill_done = (state == miss_wait) && (miss_cnt == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= idle;
            miss_cnt <= '0;
            line_vld <= '0;
        end else if (state == miss_wait) begin
            if (fill_done) begin
                state              <= respond;
                line_vld[fill_idx] <= 1'b1;
            end else begin
                miss_cnt <= miss_cnt - 1'b1;
            end
        end else if (accept && !req.op && !hit) begin
            // read miss
            state    <= miss_wait;
            miss_cnt <= cnt_t'(miss_penalty - 1);
        end else if (accept) begin
            // read hit or any write
            state <= respond;
        end else begin
            state <= idle;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            line_data[fill_idx] <= store_mem[fill_widx];
            tag_arr[fill_idx]   <= fill_widx[addr_bits-offset_bits-1:idx_bits];
            r_data              <= store_mem[fill_widx];
        end else if (accept) begin
            if (req.op) begin
                // write-through, no allocate on a write miss
                store_mem[req_widx] <= merge_bytes(store_mem[req_widx], req.w_data,
                                                   req.write_type);
                if (hit) begin
                    line_data[req_idx] <= merge_bytes(line_data[req_idx], req.w_data,
                                                      req.write_type);
                end
            end else if (hit) begin
                r_data <= line_data[req_idx];
            end else begin
                fill_widx <= req_widx;
            end
        end
    end

    // one cycle pulse per accepted access
    assign data_valid = (state == respond);

    // execute must hide valid while result stalls on the miss
    a_no_req_in_miss : assert property (@(posedge clk) disable iff (reset)
        (state == miss_wait) |-> !req.valid);

endmodule

/* src/lsu_result.sv */
`timescale 1ns/1ps

module lsu_result (
    input  logic                  clk,
    input  logic                  reset,
    lsu_req_if.result             req,
    input  logic                  data_valid,
    input  lsu_mem_pkg::data_t    r_data,
    output logic                  stall,
    output logic                  wb_valid,
    output lsu_op_pkg::reg_idx_t  wb_rd,
    output lsu_mem_pkg::data_t    wb_data,
    output lsu_op_pkg::exp_code_t wb_exp
);
    import lsu_op_pkg::*;
    import lsu_mem_pkg::*;

    logic       pend;
    logic       pend_write;
    logic [1:0] pend_off;
    reg_idx_t   pend_rd;
    mem_width_t pend_width;
    logic       pend_sign;
    exp_code_t  pend_exp;
    logic       new_op;
    logic       done;
    data_t      lane;
    data_t      ext;

    // a faulting op arrives with valid low but a code set
    assign new_op = req.valid || (req.exp != exp_none);
    // faults finish at once, cache ops on data_valid
    assign done   = pend && ((pend_exp != exp_none) || data_valid);
    assign stall  = pend && (pend_exp == exp_none) && !data_valid;

    // addressed lane down to bit 0
    assign lane = r_data >> {pend_off, 3'b000};

    always_comb begin
        case (pend_width)
            width_byte: ext = pend_sign ? {{24{lane[7]}}, lane[7:0]} : {24'b0, lane[7:0]};
            width_half: ext = pend_sign ? {{16{lane[15]}}, lane[15:0]} : {16'b0, lane[15:0]};
            default:    ext = r_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pend     <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= done;
            if (!stall) begin
                pend <= new_op;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && new_op) begin
            pend_write <= req.op;
            pend_off   <= req.addr[1:0];
            pend_rd    <= req.rd;
            pend_width <= req.width;
            pend_sign  <= req.sign_ext;
            pend_exp   <= req.exp;
        end
        if (done) begin
            wb_rd   <= pend_rd;
            wb_exp  <= pend_exp;
            // stores and faults write back zero
            wb_data <= (pend_write || (pend_exp != exp_none)) ? data_t'(0) : ext;
        end
    end

    // cache only answers ops that result has taken
    a_dv_has_owner : assert property (@(posedge clk) disable iff (reset)
        data_valid |-> (pend && (pend_exp == exp_none)));

endmodule

/* src/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  lsu_op_pkg::instr_t    in_instr,
    input  lsu_mem_pkg::data_t    in_rs1,
    input  lsu_mem_pkg::data_t    in_rs2,
    output logic                  stall,
    output logic                  wb_valid,
    output lsu_op_pkg::reg_idx_t  wb_rd,
    output lsu_mem_pkg::data_t    wb_data,
    output lsu_op_pkg::exp_code_t wb_exp
);
    import lsu_mem_pkg::*;

    // cache response, two plain wires
    logic  data_valid;
    data_t r_data;

    lsu_dec_if dec_bus ();
    lsu_req_if req_bus ();

    lsu_decode lsu_decode_inst (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .in_rs1   (in_rs1),
        .in_rs2   (in_rs2),
        .stall    (stall),
        .dec      (dec_bus.producer)
    );

    lsu_execute lsu_execute_inst (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .dec   (dec_bus.consumer),
        .req   (req_bus.producer)
    );

    lsu_dcache lsu_dcache_inst (
        .clk        (clk),
        .reset      (reset),
        .req        (req_bus.cache),
        .data_valid (data_valid),
        .r_data     (r_data)
    );

    // stall from here freezes decode and execute
    lsu_result lsu_result_inst (
        .clk        (clk),
        .reset      (reset),
        .req        (req_bus.result),
        .data_valid (data_valid),
        .r_data     (r_data),
        .stall      (stall),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .wb_exp     (wb_exp)
    );

endmodule

/* verif/lsu_clk_gen.sv */
`timescale 1ns/1ps

module lsu_clk_gen (
    output logic clk
);

    // 20 ns period, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

endmodule

/* verif/lsu_checker.sv */
`timescale 1ns/1ps

module lsu_checker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  wb_valid,
    input  lsu_op_pkg::reg_idx_t  wb_rd,
    input  lsu_mem_pkg::data_t    wb_data,
    input  lsu_op_pkg::exp_code_t wb_exp,
    output logic                  hung
);
    import lsu_op_pkg::*;
    import lsu_mem_pkg::*;

    // longest gap allowed between writebacks
    localparam int wb_limit = 50;

    // expected results, oldest first
    string     q_name [$];
    reg_idx_t  q_rd   [$];
    data_t     q_data [$];
    exp_code_t q_exp  [$];

    int test_checks  = 0;
    int test_errs    = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int total_checks = 0;
    int total_errs   = 0;

    function automatic void push_expect(string name, reg_idx_t rd, data_t data, exp_code_t ex);
        q_name.push_back(name);
        q_rd.push_back(rd);
        q_data.push_back(data);
        q_exp.push_back(ex);
    endfunction

    function automatic int outstanding();
        return q_name.size();
    endfunction

    function automatic void note_error();
        test_errs++;
        total_errs++;
    endfunction

    function automatic void check_field(string name, string field, data_t expected,
                                        data_t actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %0h actual %0h", name, field, expected, actual);
            note_error();
        end
    endfunction

    // head of the queue against the writeback ports
    function automatic void compare_head();
        string name;
        name = q_name.pop_front();
        test_checks++;
        total_checks++;
        check_field(name, "rd", data_t'(q_rd.pop_front()), data_t'(wb_rd));
        check_field(name, "data", q_data.pop_front(), wb_data);
        check_field(name, "exp", data_t'(q_exp.pop_front()), data_t'(wb_exp));
    endfunction

    function automatic void close_test(string name);
        if (test_errs == 0) begin
            tests_passed++;
            $display("%s: pass, %0d results checked", name, test_checks);
        end else begin
            tests_failed++;
            $display("%s: fail, %0d errors in %0d results", name, test_errs, test_checks);
        end
        test_checks = 0;
        test_errs   = 0;
    endfunction

    function automatic void report_counts(int extra_errs);
        $display("tests passed %0d, tests failed %0d, results checked %0d, errors %0d",
                 tests_passed, tests_failed, total_checks, total_errs + extra_errs);
    endfunction

    // sampled mid cycle, away from the rising edge
    initial begin : watch
        int waited;
        hung = 1'b0;
        while (!hung) begin
            @(negedge clk);
            if (!reset && q_name.size() != 0) begin
                waited = 0;
                while (!wb_valid && waited < wb_limit) begin
                    @(negedge clk);
                    waited++;
                end
                if (wb_valid) begin
                    compare_head();
                end else begin
                    $display("no wb_valid within %0d cycles for a %s instruction",
                             wb_limit, q_name[0]);
                    note_error();
                    hung = 1'b1;
                end
            end else if (!reset) begin
                // nothing issued, nothing may come back
                if (wb_valid) begin
                    $display("wb_valid seen with no instruction outstanding");
                    note_error();
                end
                // empty pipe has nothing to wait on
                if (stall) begin
                    $display("stall high with no instruction outstanding");
                    note_error();
                end
            end
        end
    end

endmodule

/* verif/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;
    import lsu_op_pkg::*;
    import lsu_mem_pkg::*;

    localparam int stall_limit = 40;
    localparam int drain_limit = 100;

    logic        clk;
    logic        reset;
    logic        in_valid;
    instr_t      in_instr;
    data_t       in_rs1;
    data_t       in_rs2;
    logic        stall;
    logic        wb_valid;
    reg_idx_t    wb_rd;
    data_t       wb_data;
    exp_code_t   wb_exp;
    logic        chk_hung;
    logic        tb_hung   = 1'b0;
    int          tb_errors = 0;
    logic [31:0] lcg_state;
    data_t       ref_mem [mem_words];
    string       test_name;
    logic [7:0]  a;

    lsu_clk_gen lsu_clk_gen_inst (.clk(clk));

    lsu_top lsu_top_inst (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .in_rs1   (in_rs1),
        .in_rs2   (in_rs2),
        .stall    (stall),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .wb_exp   (wb_exp)
    );

    lsu_checker lsu_checker_inst (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .wb_exp   (wb_exp),
        .hung     (chk_hung)
    );

    // lcg, low bits are weak so callers shift
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(int unsigned n);
        return (next_rand() >> 12) % n;
    endfunction

    function automatic instr_t enc_load(logic [2:0] f3, reg_idx_t rd, logic [11:0] imm);
        return {imm, 5'd1, f3, rd, opc_load};
    endfunction

    function automatic instr_t enc_store(logic [2:0] f3, logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], opc_store};
    endfunction

    // expected writeback of one op, stores go into ref_mem
    task automatic model_op(input instr_t ins, input data_t rs1, input data_t rs2,
                            output reg_idx_t rd, output data_t data, output exp_code_t ex);
        logic [2:0] f3;
        logic       is_ld;
        logic       is_st;
        data_t      addr;
        int         size;
        f3    = ins[14:12];
        is_ld = (ins[6:0] == opc_load) && (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
        is_st = (ins[6:0] == opc_store) && (f3 inside {3'd0, 3'd1, 3'd2});
        // stores never name a destination
        rd    = (ins[6:0] == opc_store) ? reg_idx_t'(0) : ins[11:7];
        data  = '0;
        ex    = exp_none;
        size  = 1 << f3[1:0];
        if (is_st) begin
            addr = rs1 + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        end else begin
            addr = rs1 + {{20{ins[31]}}, ins[31:20]};
        end
        if (!is_ld && !is_st) begin
            ex = exp_illegal;
        end else if (addr % size != 0) begin
            ex = is_st ? exp_store_misalign : exp_load_misalign;
        end else begin
            // little endian, byte i of the access sits at addr + i
            for (int i = 0; i < size; i++) begin
                if (is_st) begin
                    ref_mem[addr[7:2]][8*(addr[1:0]+i) +: 8] = rs2[8*i +: 8];
                end else begin
                    data[8*i +: 8] = ref_mem[addr[7:2]][8*(addr[1:0]+i) +: 8];
                end
            end
            if (is_ld && !f3[2] && size == 1) begin
                data = {{24{data[7]}}, data[7:0]};
            end else if (is_ld && !f3[2] && size == 2) begin
                data = {{16{data[15]}}, data[15:0]};
            end
        end
    endtask

    // drive one op and hold it until decode can take it
    task automatic issue(input instr_t ins, input data_t rs1, input data_t rs2);
        reg_idx_t  rd;
        data_t     data;
        exp_code_t ex;
        int        waited;
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        in_instr = ins;
        in_rs1   = rs1;
        in_rs2   = rs2;
        model_op(ins, rs1, rs2, rd, data, ex);
        lsu_checker_inst.push_expect(test_name, rd, data, ex);
        // stall only moves on an edge, so it is settled here
        waited = 0;
        while (stall && waited < stall_limit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (stall) begin
            $display("stall held high for %0d cycles, instruction never accepted", stall_limit);
            tb_errors++;
            tb_hung = 1'b1;
        end
    endtask

    // base and a small signed offset that add up to the address
    task automatic do_store(input logic [2:0] f3, input logic [7:0] addr, input data_t val);
        logic [11:0] imm;
        imm = 12'(rand_below(32)) - 12'd16;
        issue(enc_store(f3, imm), data_t'(addr) - {{20{imm[11]}}, imm}, val);
    endtask

    task automatic do_load(input logic [2:0] f3, input logic [7:0] addr);
        logic [11:0] imm;
        imm = 12'(rand_below(32)) - 12'd16;
        issue(enc_load(f3, reg_idx_t'(rand_below(32)), imm),
              data_t'(addr) - {{20{imm[11]}}, imm}, next_rand());
    endtask

    // idle the inputs and let every writeback come home
    task automatic finish_test();
        int waited;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        waited = 0;
        while (lsu_checker_inst.outstanding() != 0 && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        if (lsu_checker_inst.outstanding() != 0) begin
            $display("%0d results still missing after %0d cycles",
                     lsu_checker_inst.outstanding(), drain_limit);
            tb_errors++;
            tb_hung = 1'b1;
        end
        lsu_checker_inst.close_test(test_name);
    endtask

    task automatic end_run();
        lsu_checker_inst.report_counts(tb_errors);
        if (lsu_checker_inst.total_errs == 0 && tb_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin : abort_watch
        wait (tb_hung || chk_hung);
        end_run();
    end

    initial begin : stimulus
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_instr  = '0;
        in_rs1    = '0;
        in_rs2    = '0;
        lcg_state = 32'd97;
        test_name = "reset_state";
        for (int i = 0; i < mem_words; i++) begin
            ref_mem[i] = '0;
        end
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
        end
        #2;
        reset = 1'b0;

        // quiet cycles first, any wb_valid here is an error
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        for (int i = 0; i < 6; i++) begin
            do_load(3'b010, {6'(rand_below(64)), 2'b00});
            do_load(3'b000, 8'(rand_below(256)));
        end
        finish_test();

        // store, hit twice, then evict via the other tag
        test_name = "word_round_trip";
        for (int i = 0; i < 8; i++) begin
            a = {6'(rand_below(64)), 2'b00};
            do_store(3'b010, a, next_rand());
            do_load(3'b010, a);
            do_load(3'b010, a);
            do_load(3'b010, a ^ 8'h20);
            do_load(3'b010, a);
        end
        finish_test();

        test_name = "subword_store";
        for (int i = 0; i < 6; i++) begin
            a = {6'(rand_below(64)), 2'b00};
            do_store(3'b010, a, next_rand());
            do_store(3'b000, a | 8'(rand_below(4)), next_rand());
            do_store(3'b001, a | {6'd0, 1'(rand_below(2)), 1'b0}, next_rand());
            do_load(3'b010, a);
        end
        finish_test();

        // sign bits of every byte set on odd words and clear on even words
        test_name = "load_extend";
        for (int i = 0; i < 4; i++) begin
            a = {6'(rand_below(64)), 2'b00};
            do_store(3'b010, a, (i % 2 == 1) ? (next_rand() | 32'h80808080)
                                             : (next_rand() & 32'h7f7f7f7f));
            for (int j = 0; j < 4; j++) begin
                do_load(3'b000, a + 8'(j));
                do_load(3'b100, a + 8'(j));
            end
            do_load(3'b001, a);
            do_load(3'b101, a);
            do_load(3'b001, a + 8'd2);
            do_load(3'b101, a + 8'd2);
        end
        finish_test();

        test_name = "misalign";
        for (int i = 0; i < 4; i++) begin
            a = {6'(rand_below(64)), 2'b00};
            do_store(3'b010, a, next_rand());
            do_load(3'b001, a | 8'd1);
            do_store(3'b001, a | 8'd3, next_rand());
            do_load(3'b010, a | 8'(1 + rand_below(3)));
            do_store(3'b010, a | 8'(1 + rand_below(3)), next_rand());
            do_load(3'b010, a);
        end
        finish_test();

        // r-type, lwu and sd are outside the supported set
        test_name = "illegal_opcode";
        for (int i = 0; i < 3; i++) begin
            a = {6'(rand_below(64)), 2'b00};
            issue({7'b0, 5'(rand_below(32)), 5'(rand_below(32)), 3'b000,
                   5'(rand_below(32)), 7'b0110011}, next_rand(), next_rand());
            do_load(3'b110, a);
            do_store(3'b011, a, next_rand());
            do_load(3'b010, a);
        end
        finish_test();

        end_run();
    end

endmodule

/* lsu.f */
src/lsu_op_pkg.sv
src/lsu_mem_pkg.sv
src/lsu_if.sv
src/lsu_decode.sv
src/lsu_execute.sv
src/lsu_dcache.sv
src/lsu_result.sv
src/lsu_top.sv
verif/lsu_clk_gen.sv
verif/lsu_checker.sv
verif/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the lsu testbench with verilator and run it
# the log decides, a missing pass line also counts as failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f lsu.f -o lsu_sim \
    > build.log 2>&1 \
    && ./obj_dir/lsu_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation did not complete" >> sim.log; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0
